/* pr_stim.txt */
# kind addr data, all hex; c = soft-register write, m = memory word, e = final score
# five vertices, nine in-edges, three rounds; vertex 3 has no in-edges
c 00 5
c 08 9
c 10 1000
c 18 2000
c 20 3000
c 28 4000
c 30 3
m 1000 0
m 1008 2
m 1010 3
m 1018 3
m 1020 5
m 1028 1
m 1030 8
m 1038 2
m 1040 8
m 1048 1
m 2000 1
m 2008 2
m 2010 3
m 2018 0
m 2020 3
m 2028 0
m 2030 1
m 2038 4
m 2040 1
e 4000 5ddd
e 4008 1f49
e 4010 9998
e 4018 0
e 4020 1999

/* all.f */
+incdir+.
pr_pkg.sv
pr_intf.sv
pr_fifo.sv
pr_ctrl.sv
pr_fetch.sv
pr_accum.sv
pr_update.sv
pagerank_top.sv
pagerank_checker.sv
tb_pagerank.sv

/* Makefile */
VERILATOR = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_pagerank
FILELIST = all.f
LOG = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb_pagerank.sv */
`timescale 1ns/1ps
`include "pr_macros.svh"

// free-running testbench clock
module tb_clock #(
	parameter int PERIOD_NS = 100
) (
	output logic clk
);
	initial clk = 1'b0;
	always #(PERIOD_NS / 2) clk = ~clk;
endmodule

module tb_pagerank;
	logic clk;
	logic rst = 1'b1;
	pr_pkg::rd_id_e ar_id;
	pr_pkg::word_t ar_addr;
	logic ar_valid;
	logic ar_ready = 1'b0;
	pr_pkg::rd_id_e r_id = pr_pkg::RD_VERT;
	pr_pkg::word_t r_data = '0;
	logic r_valid = 1'b0;
	pr_pkg::word_t aw_addr;
	logic aw_valid;
	logic aw_ready = 1'b0;
	pr_pkg::word_t w_data;
	logic w_valid;
	logic w_ready = 1'b0;
	logic sr_req_valid = 1'b0;
	logic sr_req_write = 1'b0;
	logic [`PR_SR_ADDR_W-1:0] sr_req_addr = '0;
	pr_pkg::word_t sr_req_data = '0;
	logic sr_resp_valid;
	pr_pkg::word_t sr_resp_data;
	logic done;

	// word memory, keyed by byte address
	pr_pkg::word_t mem [pr_pkg::word_t];
	// stim file contents
	pr_pkg::word_t cfg_addr [$];
	pr_pkg::word_t cfg_data [$];
	pr_pkg::word_t exp_addr [$];
	pr_pkg::word_t exp_data [$];
	pr_pkg::word_t n_vert = '0;
	pr_pkg::word_t n_inedges = '0;
	pr_pkg::word_t n_rounds = '0;
	pr_pkg::word_t v_base = '0;
	pr_pkg::word_t buf0 = '0;
	pr_pkg::word_t buf1 = '0;
	// reads in flight, answered in order
	pr_pkg::word_t rd_addr_q [$];
	pr_pkg::rd_id_e rd_id_q [$];
	longint rd_due_q [$];
	// write channels complete on their own
	pr_pkg::word_t aw_q [$];
	pr_pkg::word_t w_q [$];
	int seed = 32'h6f15;
	longint cycles = 0;
	longint limit = 0;
	logic limit_set = 1'b0;
	int writes = 0;
	int errors = 0;
	int checks = 0;
	int done_rises = 0;
	logic done_prev = 1'b0;

	tb_clock #(.PERIOD_NS(100)) u_clock (.clk(clk));

	pagerank_top UUT (.*);

	bind pagerank_top pagerank_checker u_checker (
		.clk(clk),
		.rst(rst),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.ar_addr(ar_addr),
		.ar_id(ar_id),
		.aw_valid(aw_valid),
		.aw_ready(aw_ready),
		.aw_addr(aw_addr),
		.w_valid(w_valid),
		.w_ready(w_ready),
		.w_data(w_data),
		.done(done)
	);

	function automatic void compare_word(string name, pr_pkg::word_t got, pr_pkg::word_t exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("ERROR: %s = 0x%h, expected 0x%h", name, got, exp);
		end
	endfunction

	function automatic void expect_true(logic cond, string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("%s", what);
		end
	endfunction

	// unwritten words read as zero
	function automatic pr_pkg::word_t read_mem(pr_pkg::word_t a);
		return mem.exists(a) ? mem[a] : '0;
	endfunction

	// in-edge count from the vertex array in the memory image
	function automatic pr_pkg::word_t in_degree(pr_pkg::word_t v);
		pr_pkg::word_t lo;
		pr_pkg::word_t hi;
		lo = read_mem(v_base + 16 * v);
		hi = (v == n_vert - 1) ? n_inedges : read_mem(v_base + 16 * (v + 1));
		return hi - lo;
	endfunction

	// round k writes buf1 if k is odd, buf0 otherwise, one word per vertex in order
	function automatic void commit_write(pr_pkg::word_t a, pr_pkg::word_t d);
		longint round;
		longint idx;
		pr_pkg::word_t exp_buf;
		round = writes / n_vert + 1;
		idx = writes % n_vert;
		exp_buf = round[0] ? buf1 : buf0;
		compare_word("aw_addr", a, exp_buf + 8 * idx);
		if (round > 1 && in_degree(idx) == 0)
			compare_word("w_data", d, '0);
		mem[a] = d;
		writes++;
	endfunction

	task automatic load_stim();
		int fd;
		int n;
		string line;
		pr_pkg::word_t a;
		pr_pkg::word_t d;
		fd = $fopen("pr_stim.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("cannot open pr_stim.txt");
			return;
		end
		while ($fgets(line, fd) > 0) begin
			// comment and blank lines
			if (line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line.substr(2, line.len() - 1), "%h %h", a, d);
			if (n != 2) begin
				errors++;
				$display("malformed stim line: %s", line);
				continue;
			end
			case (line[0])
				"c": begin
					cfg_addr.push_back(a);
					cfg_data.push_back(d);
					if (a == `PR_REG_N_VERT)
						n_vert = d;
					if (a == `PR_REG_N_INEDGES)
						n_inedges = d;
					if (a == `PR_REG_N_ROUNDS)
						n_rounds = d;
					if (a == `PR_REG_VADDR)
						v_base = d;
					if (a == `PR_REG_BUF0)
						buf0 = d;
					if (a == `PR_REG_BUF1)
						buf1 = d;
				end
				"m": mem[a] = d;
				"e": begin
					exp_addr.push_back(a);
					exp_data.push_back(d);
				end
				default: begin
					errors++;
					$display("unknown stim line kind: %s", line);
				end
			endcase
		end
		$fclose(fd);
	endtask

	task automatic write_reg(input pr_pkg::word_t a, input pr_pkg::word_t d);
		@(posedge clk);
		sr_req_valid <= 1'b1;
		sr_req_write <= 1'b1;
		sr_req_addr <= a[`PR_SR_ADDR_W-1:0];
		sr_req_data <= d;
		@(posedge clk);
		sr_req_valid <= 1'b0;
		sr_req_write <= 1'b0;
	endtask

	task automatic read_reg(input pr_pkg::word_t a, output pr_pkg::word_t d);
		@(posedge clk);
		sr_req_valid <= 1'b1;
		sr_req_write <= 1'b0;
		sr_req_addr <= a[`PR_SR_ADDR_W-1:0];
		// request sampled on this edge, response not yet due
		@(posedge clk);
		sr_req_valid <= 1'b0;
		expect_true(!sr_resp_valid, "sr_resp_valid high in the request cycle");
		@(posedge clk);
		expect_true(sr_resp_valid, "sr_resp_valid not high one cycle after a read");
		d = sr_resp_data;
	endtask

	always @(posedge clk)
		cycles <= cycles + 1;

	// memory model with random ready stalls and 0 to 3 cycles of read delay
	always @(posedge clk) begin
		if (rst) begin
			ar_ready <= 1'b0;
			aw_ready <= 1'b0;
			w_ready <= 1'b0;
			r_valid <= 1'b0;
		end else begin
			ar_ready <= ($random(seed) & 3) != 0;
			aw_ready <= ($random(seed) & 3) != 0;
			w_ready <= ($random(seed) & 3) != 0;
			if (ar_valid && ar_ready) begin
				rd_addr_q.push_back(ar_addr);
				rd_id_q.push_back(ar_id);
				rd_due_q.push_back(cycles + 1 + ($random(seed) & 3));
			end
			// only the head may answer, so order is kept
			if (rd_due_q.size() > 0 && rd_due_q[0] <= cycles) begin
				r_valid <= 1'b1;
				r_id <= rd_id_q.pop_front();
				r_data <= read_mem(rd_addr_q.pop_front());
				rd_due_q.delete(0);
			end else begin
				r_valid <= 1'b0;
			end
			if (aw_valid && aw_ready)
				aw_q.push_back(aw_addr);
			if (w_valid && w_ready)
				w_q.push_back(w_data);
			if (aw_q.size() > 0 && w_q.size() > 0)
				commit_write(aw_q.pop_front(), w_q.pop_front());
		end
	end

	// done must rise once and never fall
	always @(posedge clk) begin
		if (done && !done_prev)
			done_rises++;
		if (done_prev && !done)
			expect_true(1'b0, "done fell without a new start");
		done_prev = done;
	end

	// run limit from the graph size
	initial begin
		wait (limit_set);
		while (cycles < limit)
			@(posedge clk);
		$display("timeout: done not seen within %0d cycles", limit);
		$display("checks run: %0d, errors: %0d", checks, errors + 1);
		$display("Checks failed");
		$finish;
	end

	initial begin
		pr_pkg::word_t got;
		load_stim();
		limit = n_rounds * (n_vert * (`PR_DIV_CYCLES + 8) + n_inedges * 8) + 1000;
		limit_set = 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		@(posedge clk);
		expect_true(!ar_valid && !aw_valid && !w_valid && !sr_resp_valid && !done,
			"an output is high after reset");

		for (int i = 0; i < cfg_addr.size(); i++)
			write_reg(cfg_addr[i], cfg_data[i]);
		read_reg(`PR_REG_ROUNDS_DONE, got);
		compare_word("sr_resp_data (rounds done before start)", got, '0);

		write_reg(`PR_REG_START, 64'd1);
		while (!done)
			@(posedge clk);

		// status after the run
		read_reg(`PR_REG_ROUNDS_DONE, got);
		compare_word("sr_resp_data (rounds done)", got, n_rounds);
		read_reg(`PR_REG_VERT_LEFT, got);
		compare_word("sr_resp_data (vertices left)", got, '0);
		read_reg(`PR_REG_EDGE_LEFT, got);
		compare_word("sr_resp_data (edges left)", got, '0);

		// final buffer against the stim file
		for (int i = 0; i < exp_addr.size(); i++)
			compare_word($sformatf("score at 0x%h", exp_addr[i]), read_mem(exp_addr[i]),
				exp_data[i]);
		compare_word("write count", pr_pkg::word_t'(writes), n_rounds * n_vert);
		compare_word("done rise count", pr_pkg::word_t'(done_rises), 64'd1);
		expect_true(exp_addr.size() > 0, "stim file holds no expected scores");

		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end
endmodule

/* pagerank_checker.sv */
`timescale 1ns/1ps

module pagerank_checker (
	input logic clk,
	input logic rst,
	input logic ar_valid,
	input logic ar_ready,
	input pr_pkg::word_t ar_addr,
	input pr_pkg::rd_id_e ar_id,
	input logic aw_valid,
	input logic aw_ready,
	input pr_pkg::word_t aw_addr,
	input logic w_valid,
	input logic w_ready,
	input pr_pkg::word_t w_data,
	input logic done
);
	// read request waits for ar_ready unchanged
	assert property (@(posedge clk) disable iff (rst)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr) && $stable(ar_id))
		else $error("read request changed while ar_ready was low");

	// write address holds until accepted
	assert property (@(posedge clk) disable iff (rst)
		aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr))
		else $error("write address changed while aw_ready was low");

	// write data holds until accepted
	assert property (@(posedge clk) disable iff (rst)
		w_valid && !w_ready |=> w_valid && $stable(w_data))
		else $error("write data changed while w_ready was low");

	// no writes once the run is over
	assert property (@(posedge clk) disable iff (rst) done |-> !aw_valid)
		else $error("write address issued while done was high");
endmodule

/* pagerank_top.sv */
`timescale 1ns/1ps
`include "pr_macros.svh"

module pagerank_top (
	input logic clk,
	input logic rst,
	output pr_pkg::rd_id_e ar_id,
	output pr_pkg::word_t ar_addr,
	output logic ar_valid,
	input logic ar_ready,
	input pr_pkg::rd_id_e r_id,
	input pr_pkg::word_t r_data,
	input logic r_valid,
	output pr_pkg::word_t aw_addr,
	output logic aw_valid,
	input logic aw_ready,
	output pr_pkg::word_t w_data,
	output logic w_valid,
	input logic w_ready,
	input logic sr_req_valid,
	input logic sr_req_write,
	input logic [`PR_SR_ADDR_W-1:0] sr_req_addr,
	input pr_pkg::word_t sr_req_data,
	output logic sr_resp_valid,
	output pr_pkg::word_t sr_resp_data,
	output logic done
);
	pr_cfg_if cfg_if ();
	pr_stream_if stream_if ();

	logic init_start;
	logic init_done;
	pr_pkg::word_t init_val;
	logic upd_valid;
	logic upd_ready;
	pr_pkg::upd_req_t upd_data;

	pr_ctrl u_ctrl (
		.clk(clk),
		.rst(rst),
		.sr_req_valid(sr_req_valid),
		.sr_req_write(sr_req_write),
		.sr_req_addr(sr_req_addr),
		.sr_req_data(sr_req_data),
		.sr_resp_valid(sr_resp_valid),
		.sr_resp_data(sr_resp_data),
		.cfg(cfg_if.ctrl),
		.init_start(init_start),
		.init_done(init_done),
		.init_val_ok(),
		.done(done)
	);

	pr_fetch u_fetch (
		.clk(clk),
		.rst(rst),
		.cfg(cfg_if.fetch),
		.init_val(init_val),
		.ar_id(ar_id),
		.ar_addr(ar_addr),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.r_id(r_id),
		.r_data(r_data),
		.r_valid(r_valid),
		.stream(stream_if.src)
	);

	pr_accum u_accum (
		.clk(clk),
		.rst(rst),
		.cfg(cfg_if.accum),
		.stream(stream_if.dst),
		.upd_valid(upd_valid),
		.upd_ready(upd_ready),
		.upd_data(upd_data)
	);

	pr_update u_update (
		.clk(clk),
		.rst(rst),
		.cfg(cfg_if.update),
		.upd_valid(upd_valid),
		.upd_ready(upd_ready),
		.upd_data(upd_data),
		.init_start(init_start),
		.init_done(init_done),
		.init_val(init_val),
		.aw_addr(aw_addr),
		.aw_valid(aw_valid),
		.aw_ready(aw_ready),
		.w_data(w_data),
		.w_valid(w_valid),
		.w_ready(w_ready)
	);
endmodule

/* pr_update.sv */
`timescale 1ns/1ps
`include "pr_macros.svh"

module pr_update (
	input logic clk,
	input logic rst,
	pr_cfg_if.update cfg,
	input logic upd_valid,
	output logic upd_ready,
	input pr_pkg::upd_req_t upd_data,
	input logic init_start,
	output logic init_done,
	output pr_pkg::word_t init_val,
	output pr_pkg::word_t aw_addr,
	output logic aw_valid,
	input logic aw_ready,
	output pr_pkg::word_t w_data,
	output logic w_valid,
	input logic w_ready
);
	localparam int W = `PR_WORD_W;
	localparam int CNT_W = $clog2(`PR_DIV_CYCLES);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`PR_DIV_CYCLES - 1);

	typedef enum logic [1:0] {S_IDLE, S_DIV, S_WRITE} state_e;

	state_e state;
	logic is_init;
	logic [CNT_W-1:0] cnt;
	// dividend shifts out of quo while quotient bits shift in
	pr_pkg::word_t quo;
	pr_pkg::word_t rem;
	pr_pkg::word_t divisor;
	pr_pkg::word_t vcount;
	logic [W:0] trial;
	logic aw_done;
	logic w_done;

	// init request wins over a waiting score
	assign upd_ready = (state == S_IDLE) && !init_start;
	assign trial = {rem, quo[W-1]};
	assign aw_done = !aw_valid || aw_ready;
	assign w_done = !w_valid || w_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			is_init <= 1'b0;
			cnt <= '0;
			vcount <= '0;
			init_done <= 1'b0;
			cfg.round_done <= 1'b0;
			aw_valid <= 1'b0;
			w_valid <= 1'b0;
		end else begin
			init_done <= 1'b0;
			cfg.round_done <= 1'b0;
			case (state)
				S_IDLE: begin
					cnt <= '0;
					if (init_start || upd_valid) begin
						is_init <= init_start;
						state <= S_DIV;
					end
				end
				S_DIV: begin
					cnt <= cnt + 1'b1;
					if (cnt == LAST_CNT) begin
						if (is_init) begin
							init_done <= 1'b1;
							state <= S_IDLE;
						end else begin
							aw_valid <= 1'b1;
							w_valid <= 1'b1;
							state <= S_WRITE;
						end
					end
				end
				default: begin
					// address and data channels finish in any order
					if (aw_ready)
						aw_valid <= 1'b0;
					if (w_ready)
						w_valid <= 1'b0;
					if (aw_done && w_done) begin
						state <= S_IDLE;
						if (vcount == cfg.n_vertices - 1'b1) begin
							vcount <= '0;
							cfg.round_done <= 1'b1;
						end else begin
							vcount <= vcount + 1'b1;
						end
					end
				end
			endcase
		end
	end

	// restoring divider, one quotient bit per cycle
	// a zero divisor always passes the trial and gives all ones
	always_ff @(posedge clk) begin
		if (state == S_IDLE) begin
			rem <= '0;
			if (init_start) begin
				quo <= pr_pkg::word_t'(1) << `PR_PREC;
				divisor <= cfg.n_vertices;
			end else begin
				quo <= upd_data.sum;
				divisor <= upd_data.n_out;
			end
		end else if (state == S_DIV && cnt != LAST_CNT) begin
			if (trial >= {1'b0, divisor}) begin
				rem <= trial[W-1:0] - divisor;
				quo <= {quo[W-2:0], 1'b1};
			end else begin
				rem <= trial[W-1:0];
				quo <= {quo[W-2:0], 1'b0};
			end
		end
	end

	// result capture on the final divider cycle
	always_ff @(posedge clk) begin
		if (state == S_DIV && cnt == LAST_CNT) begin
			if (is_init) begin
				init_val <= quo;
			end else begin
				aw_addr <= cfg.wr_base + (vcount << 3);
				w_data <= quo;
			end
		end
	end
endmodule

/* pr_accum.sv */
`timescale 1ns/1ps
`include "pr_macros.svh"

module pr_accum (
	input logic clk,
	input logic rst,
	pr_cfg_if.accum cfg,
	pr_stream_if.dst stream,
	output logic upd_valid,
	input logic upd_ready,
	output pr_pkg::upd_req_t upd_data
);
	typedef enum logic [2:0] {S_IDLE, S_FIRST, S_HEAD, S_SUM, S_OFFER} state_e;

	state_e state;
	// record of the vertex being summed, replaced by the next one on its head
	pr_pkg::vert_rec_t look;
	pr_pkg::word_t vcount;
	pr_pkg::word_t edges_left;
	pr_pkg::word_t sum;
	pr_pkg::word_t n_out;
	logic last;
	logic head_go;

	assign last = (vcount == cfg.n_vertices - 1'b1);
	// the last vertex has no successor and ends at n_inedges
	assign head_go = (state == S_HEAD) && (last || stream.vert_valid);

	assign stream.vert_take = stream.vert_valid
		&& ((state == S_FIRST) || (state == S_HEAD && !last));
	assign stream.val_take = stream.val_valid && (state == S_SUM) && (edges_left != '0);

	assign upd_valid = (state == S_OFFER);
	assign upd_data = '{sum: sum, n_out: n_out};

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			vcount <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (cfg.round_start) begin
						vcount <= '0;
						state <= S_FIRST;
					end
				end
				S_FIRST: begin
					if (stream.vert_valid)
						state <= S_HEAD;
				end
				S_HEAD: begin
					if (head_go)
						state <= S_SUM;
				end
				S_SUM: begin
					if (edges_left == '0)
						state <= S_OFFER;
				end
				default: begin
					// held until pr_update goes idle
					if (upd_ready) begin
						if (last) begin
							state <= S_IDLE;
						end else begin
							vcount <= vcount + 1'b1;
							state <= S_HEAD;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (stream.vert_take)
			look <= stream.vert_data;
		// in-edge count is the gap to the next record's offset
		if (head_go) begin
			n_out <= look.n_out;
			sum <= '0;
			edges_left <= (last ? cfg.n_inedges : stream.vert_data.ie_offset) - look.ie_offset;
		end
		if (stream.val_take) begin
			sum <= sum + stream.val_data;
			edges_left <= edges_left - 1'b1;
		end
	end
endmodule

/* pr_fetch.sv */
`timescale 1ns/1ps
`include "pr_macros.svh"

module pr_fetch (
	input logic clk,
	input logic rst,
	pr_cfg_if.fetch cfg,
	input pr_pkg::word_t init_val,
	output pr_pkg::rd_id_e ar_id,
	output pr_pkg::word_t ar_addr,
	output logic ar_valid,
	input logic ar_ready,
	input pr_pkg::rd_id_e r_id,
	input pr_pkg::word_t r_data,
	input logic r_valid,
	pr_stream_if.src stream
);
	localparam int DEPTH = `PR_FIFO_DEPTH;
	localparam int CNT_W = $clog2(DEPTH) + 1;

	// fetch positions and what is left of this round
	pr_pkg::word_t v_addr;
	pr_pkg::word_t ie_addr;
	pr_pkg::word_t vert_left;
	pr_pkg::word_t edge_left;
	logic v_half;
	// reads in flight per stream, counted from the moment they sit on ar
	logic [CNT_W-1:0] v_out;
	logic [CNT_W-1:0] e_out;
	logic [CNT_W-1:0] s_out;
	logic [CNT_W-1:0] v_cnt;
	logic [CNT_W-1:0] e_cnt;
	logic [CNT_W-1:0] s_cnt;
	logic v_empty;
	logic e_empty;
	logic s_empty;
	logic s_full;
	pr_pkg::word_t e_head;
	// response register, FIFO writes happen one cycle after r_valid
	logic rq_valid;
	pr_pkg::rd_id_e rq_id;
	pr_pkg::word_t rq_data;
	logic rq_half;
	pr_pkg::word_t v_lo;
	// scheduler
	pr_pkg::rd_id_e rr;
	pr_pkg::rd_id_e grant;
	logic [2:0] want;
	logic grant_any;
	logic ar_free;
	logic issue_v;
	logic issue_e;
	logic issue_s;
	logic ret_v;
	logic ret_e;
	logic ret_s;
	logic init_push;

	// a stream asks only if its FIFO has room for all reads in flight plus one
	assign want[0] = (vert_left != '0) && (int'(v_cnt) + int'(v_out) < DEPTH);
	assign want[1] = (edge_left != '0) && (int'(e_cnt) + int'(e_out) < DEPTH);
	assign want[2] = !cfg.first_round && !e_empty && (int'(s_cnt) + int'(s_out) < DEPTH);
	// round 1 has no previous scores to read
	assign init_push = cfg.first_round && !e_empty && !s_full;

	assign ar_free = !ar_valid || ar_ready;
	assign issue_v = ar_free && grant_any && (grant == pr_pkg::RD_VERT);
	assign issue_e = ar_free && grant_any && (grant == pr_pkg::RD_EDGE);
	assign issue_s = ar_free && grant_any && (grant == pr_pkg::RD_SCORE);
	assign ret_v = rq_valid && (rq_id == pr_pkg::RD_VERT);
	assign ret_e = rq_valid && (rq_id == pr_pkg::RD_EDGE);
	assign ret_s = rq_valid && (rq_id == pr_pkg::RD_SCORE);

	// round robin starting at rr, lowest offset wins
	always_comb begin
		grant = pr_pkg::RD_VERT;
		grant_any = 1'b0;
		for (int i = 2; i >= 0; i--) begin
			if (want[(int'(rr) + i) % 3]) begin
				grant = pr_pkg::rd_id_e'((int'(rr) + i) % 3);
				grant_any = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ar_valid <= 1'b0;
			rr <= pr_pkg::RD_VERT;
		end else if (ar_free) begin
			ar_valid <= grant_any;
			if (grant_any)
				rr <= (grant == pr_pkg::RD_SCORE) ? pr_pkg::RD_VERT
					: pr_pkg::rd_id_e'(grant + 2'd1);
		end
	end

	// request payload holds while ar waits for ready
	always_ff @(posedge clk) begin
		if (ar_free && grant_any) begin
			ar_id <= grant;
			case (grant)
				pr_pkg::RD_VERT: ar_addr <= v_half ? v_addr + 8 : v_addr;
				pr_pkg::RD_EDGE: ar_addr <= ie_addr;
				default: ar_addr <= cfg.rd_base + (e_head << 3);
			endcase
		end
	end

	// a vertex record takes two reads, 16 bytes apart per record
	always_ff @(posedge clk) begin
		if (rst) begin
			v_addr <= '0;
			ie_addr <= '0;
			vert_left <= '0;
			edge_left <= '0;
			v_half <= 1'b0;
		end else if (cfg.round_start) begin
			v_addr <= cfg.v_base;
			ie_addr <= cfg.ie_base;
			vert_left <= cfg.n_vertices;
			edge_left <= cfg.n_inedges;
			v_half <= 1'b0;
		end else begin
			if (issue_v) begin
				v_half <= !v_half;
				if (v_half) begin
					v_addr <= v_addr + 16;
					vert_left <= vert_left - 1'b1;
				end
			end
			if (issue_e) begin
				ie_addr <= ie_addr + 8;
				edge_left <= edge_left - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			v_out <= '0;
			e_out <= '0;
			s_out <= '0;
		end else begin
			v_out <= v_out + issue_v - ret_v;
			e_out <= e_out + issue_e - ret_e;
			s_out <= s_out + issue_s - ret_s;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			rq_valid <= 1'b0;
		else
			rq_valid <= r_valid;
	end

	always_ff @(posedge clk) begin
		rq_id <= r_id;
		rq_data <= r_data;
	end

	// responses come back in order, so vertex words pair up by parity
	always_ff @(posedge clk) begin
		if (rst)
			rq_half <= 1'b0;
		else if (ret_v)
			rq_half <= !rq_half;
	end

	always_ff @(posedge clk) begin
		if (ret_v && !rq_half)
			v_lo <= rq_data;
	end

	pr_fifo #(.item_t(pr_pkg::vert_rec_t)) u_vert_fifo (
		.clk(clk),
		.rst(rst),
		.wr_en(ret_v && rq_half),
		.wr_data('{ie_offset: v_lo, n_out: rq_data}),
		.rd_en(stream.vert_take),
		.rd_data(stream.vert_data),
		.full(),
		.empty(v_empty),
		.count(v_cnt)
	);

	// edge head is popped when its score read is loaded onto ar
	pr_fifo #(.item_t(pr_pkg::word_t)) u_edge_fifo (
		.clk(clk),
		.rst(rst),
		.wr_en(ret_e),
		.wr_data(rq_data),
		.rd_en(issue_s || init_push),
		.rd_data(e_head),
		.full(),
		.empty(e_empty),
		.count(e_cnt)
	);

	pr_fifo #(.item_t(pr_pkg::word_t)) u_score_fifo (
		.clk(clk),
		.rst(rst),
		.wr_en(ret_s || init_push),
		.wr_data(init_push ? init_val : rq_data),
		.rd_en(stream.val_take),
		.rd_data(stream.val_data),
		.full(s_full),
		.empty(s_empty),
		.count(s_cnt)
	);

	assign stream.vert_valid = !v_empty;
	assign stream.val_valid = !s_empty;
	assign cfg.vert_left = vert_left;
	assign cfg.edge_left = edge_left;
endmodule

/* pr_ctrl.sv */
`timescale 1ns/1ps
`include "pr_macros.svh"

module pr_ctrl (
	input logic clk,
	input logic rst,
	input logic sr_req_valid,
	input logic sr_req_write,
	input logic [`PR_SR_ADDR_W-1:0] sr_req_addr,
	input pr_pkg::word_t sr_req_data,
	output logic sr_resp_valid,
	output pr_pkg::word_t sr_resp_data,
	pr_cfg_if.ctrl cfg,
	output logic init_start,
	input logic init_done,
	output logic init_val_ok,
	output logic done
);
	typedef enum logic [1:0] {S_IDLE, S_INIT, S_LAUNCH, S_RUN} state_e;

	state_e state;
	pr_pkg::word_t n_rounds;
	pr_pkg::word_t rounds_done;
	pr_pkg::word_t buf0;
	pr_pkg::word_t buf1;
	logic wr_req;
	logic rd_req;
	logic start;

	assign wr_req = sr_req_valid && sr_req_write;
	assign rd_req = sr_req_valid && !sr_req_write;
	// a start while a run is in progress is ignored
	assign start = wr_req && (sr_req_addr == `PR_REG_START) && (state == S_IDLE);

	// host-written configuration
	always_ff @(posedge clk) begin
		if (wr_req) begin
			case (sr_req_addr)
				`PR_REG_N_VERT: cfg.n_vertices <= sr_req_data;
				`PR_REG_N_INEDGES: cfg.n_inedges <= sr_req_data;
				`PR_REG_VADDR: cfg.v_base <= sr_req_data;
				`PR_REG_IEADDR: cfg.ie_base <= sr_req_data;
				`PR_REG_BUF0: buf0 <= sr_req_data;
				`PR_REG_BUF1: buf1 <= sr_req_data;
				`PR_REG_N_ROUNDS: n_rounds <= sr_req_data;
				default: ;
			endcase
		end
	end

	// run sequencing
	// init division first, then one round_start per round
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			init_start <= 1'b0;
			init_val_ok <= 1'b0;
			cfg.round_start <= 1'b0;
			cfg.first_round <= 1'b0;
			rounds_done <= '0;
			done <= 1'b0;
		end else begin
			init_start <= 1'b0;
			cfg.round_start <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start) begin
						init_start <= 1'b1;
						init_val_ok <= 1'b0;
						rounds_done <= '0;
						done <= 1'b0;
						cfg.first_round <= 1'b1;
						state <= S_INIT;
					end
				end
				S_INIT: begin
					if (init_done) begin
						init_val_ok <= 1'b1;
						state <= S_LAUNCH;
					end
				end
				S_LAUNCH: begin
					if (rounds_done == n_rounds) begin
						done <= 1'b1;
						cfg.first_round <= 1'b0;
						state <= S_IDLE;
					end else begin
						cfg.round_start <= 1'b1;
						state <= S_RUN;
					end
				end
				default: begin
					if (cfg.round_done) begin
						rounds_done <= rounds_done + 1'b1;
						cfg.first_round <= 1'b0;
						state <= S_LAUNCH;
					end
				end
			endcase
		end
	end

	// score buffers
	// round 1 reads buf0 and writes buf1, then they swap every round
	always_ff @(posedge clk) begin
		if (start) begin
			cfg.rd_base <= buf0;
			cfg.wr_base <= buf1;
		end else if (state == S_RUN && cfg.round_done) begin
			cfg.rd_base <= cfg.wr_base;
			cfg.wr_base <= cfg.rd_base;
		end
	end

	// status reads answer one cycle after the request
	always_ff @(posedge clk) begin
		if (rst)
			sr_resp_valid <= 1'b0;
		else
			sr_resp_valid <= rd_req;
	end

	always_ff @(posedge clk) begin
		if (rd_req) begin
			case (sr_req_addr)
				`PR_REG_ROUNDS_DONE: sr_resp_data <= rounds_done;
				`PR_REG_VERT_LEFT: sr_resp_data <= cfg.vert_left;
				`PR_REG_EDGE_LEFT: sr_resp_data <= cfg.edge_left;
				default: sr_resp_data <= '0;
			endcase
		end
	end
endmodule

/* pr_fifo.sv */
`timescale 1ns/1ps
`include "pr_macros.svh"

module pr_fifo #(
	parameter type item_t = logic [`PR_WORD_W-1:0]
) (
	input logic clk,
	input logic rst,
	input logic wr_en,
	input item_t wr_data,
	input logic rd_en,
	output item_t rd_data,
	output logic full,
	output logic empty,
	output logic [$clog2(`PR_FIFO_DEPTH):0] count
);
	localparam int DEPTH = `PR_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = PTR_W + 1;

	item_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic do_wr;
	logic do_rd;

	// writes into a full FIFO and reads from an empty one are dropped
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;
	assign full = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);
	// show-ahead, the head entry is always on rd_data
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	// pointers wrap on their own since depth is a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end
endmodule

/* pr_intf.sv */
`timescale 1ns/1ps

// configuration and round handshake shared by all engine blocks
interface pr_cfg_if;
	pr_pkg::word_t n_vertices;
	pr_pkg::word_t n_inedges;
	pr_pkg::word_t v_base;
	pr_pkg::word_t ie_base;
	pr_pkg::word_t rd_base;
	pr_pkg::word_t wr_base;
	logic first_round;
	logic round_start;
	logic round_done;
	pr_pkg::word_t vert_left;
	pr_pkg::word_t edge_left;

	modport ctrl (
		output n_vertices, n_inedges, v_base, ie_base, rd_base, wr_base,
		output first_round, round_start,
		input round_done, vert_left, edge_left
	);

	modport fetch (
		input n_vertices, n_inedges, v_base, ie_base, rd_base, first_round, round_start,
		output vert_left, edge_left
	);

	modport accum (
		input n_vertices, n_inedges, round_start
	);

	modport update (
		input n_vertices, wr_base,
		output round_done
	);
endinterface

// FIFO heads from the read scheduler to the summation stage
interface pr_stream_if;
	logic vert_valid;
	pr_pkg::vert_rec_t vert_data;
	logic vert_take;
	logic val_valid;
	pr_pkg::word_t val_data;
	logic val_take;

	modport src (
		output vert_valid, vert_data, val_valid, val_data,
		input vert_take, val_take
	);

	modport dst (
		input vert_valid, vert_data, val_valid, val_data,
		output vert_take, val_take
	);
endinterface

/* pr_pkg.sv */
`include "pr_macros.svh"

package pr_pkg;

	// one bus word, used for data and byte addresses alike
	typedef logic [`PR_WORD_W-1:0] word_t;

	// vertex record as two consecutive words in memory
	// ie_offset sits at the lower address
	typedef struct packed {
		word_t ie_offset;
		word_t n_out;
	} vert_rec_t;

	// read stream tag, carried on ar_id and returned on r_id
	typedef enum logic [1:0] {
		RD_VERT = 2'd0,
		RD_EDGE = 2'd1,
		RD_SCORE = 2'd2
	} rd_id_e;

	// division request from the summation stage
	typedef struct packed {
		word_t sum;
		word_t n_out;
	} upd_req_t;

endpackage

/* pr_macros.svh */
`ifndef PR_MACROS_SVH
`define PR_MACROS_SVH

// memory bus data and address width
`define PR_WORD_W 64

// fraction bits of a fixed-point score
`define PR_PREC 16

// entries in each internal FIFO
`define PR_FIFO_DEPTH 16

// one load cycle plus one cycle per quotient bit
`define PR_DIV_CYCLES 65

// soft-register address width
`define PR_SR_ADDR_W 32

// configuration registers, written by the host
`define PR_REG_N_VERT 32'h00
`define PR_REG_N_INEDGES 32'h08
`define PR_REG_VADDR 32'h10
`define PR_REG_IEADDR 32'h18
`define PR_REG_BUF0 32'h20
`define PR_REG_BUF1 32'h28
`define PR_REG_N_ROUNDS 32'h30
`define PR_REG_START 32'h38

// status registers, read only
`define PR_REG_ROUNDS_DONE 32'h40
`define PR_REG_VERT_LEFT 32'h48
`define PR_REG_EDGE_LEFT 32'h50

`endif
